//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_ccc_top
FILELIST = ccc_top.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- ccc_top.f
+incdir+include
hdl/i3c_ccc_pkg.sv
hdl/ccc_ctrl_pkg.sv
hdl/ccc_fsm.sv
hdl/ccc_addr_match.sv
hdl/ccc_set_handler.sv
hdl/ccc_get_handler.sv
hdl/ccc_top.sv
dv/tb_ccc_top.sv

//--- include/ccc_bus_model.svh
// CCC testbench PHY model
`ifndef CCC_BUS_MODEL_SVH
`define CCC_BUS_MODEL_SVH

  // Random PHY answer latency
  task automatic phy_delay();
    repeat ($urandom_range(LAT_MIN, LAT_MAX)) @(posedge clk_i);
  endtask

  task automatic send_ccc(input logic [7:0] code);
    @(posedge clk_i);
    ccc_i       <= code;
    ccc_valid_i <= 1'b1;
    @(posedge clk_i);
    ccc_valid_i <= 1'b0;
  endtask

  // Answer a byte request, or a bit request with the T-bit in bit 7
  task automatic answer_rx(input logic want_byte, input logic [7:0] value);
    @(negedge clk_i);
    while (!(want_byte ? rx_req_byte_o : rx_req_bit_o)) @(negedge clk_i);
    phy_delay();
    rx_data_i <= value;
    rx_done_i <= 1'b1;
    @(posedge clk_i);
    rx_done_i <= 1'b0;
  endtask

  task automatic answer_tx();
    @(negedge clk_i);
    while (!(tx_req_byte_o || tx_req_bit_o)) @(negedge clk_i);
    phy_delay();
    tx_done_i <= 1'b1;
    @(posedge clk_i);
    tx_done_i <= 1'b0;
  endtask

  task automatic send_rstart();
    @(posedge clk_i);
    rstart_det_i <= 1'b1;
    @(posedge clk_i);
    rstart_det_i <= 1'b0;
  endtask

  task automatic send_stop();
    @(posedge clk_i);
    stop_det_i <= 1'b1;
    @(posedge clk_i);
    stop_det_i <= 1'b0;
    n_stop++;
    @(negedge clk_i);
    while (!done_fsm_o) @(negedge clk_i);
    // Idle follows done, WaitCcc one cycle later
    @(posedge clk_i);
  endtask

  // Code, T-bit, Sr, address and the ACK bit
  task automatic open_direct(input logic [7:0] code, input logic [6:0] addr,
                             input logic rnw);
    send_ccc(code);
    answer_rx(1'b0, 8'h80);
    send_rstart();
    answer_rx(1'b1, {addr, rnw});
    answer_tx();
  endtask

  task automatic send_bcast(input logic [7:0] code, input logic [15:0] data,
                            input int nbytes);
    int i;
    send_ccc(code);
    answer_rx(1'b0, 8'h80);
    for (i = 0; i < nbytes; i++) begin
      answer_rx(1'b1, data[15 - 8 * i -: 8]);
      answer_rx(1'b0, 8'h80);
    end
    send_stop();
  endtask

`endif

//--- dv/tb_ccc_top.sv
// CCC handler testbench
`timescale 1ns/10ps

module tb_ccc_top
  import i3c_ccc_pkg::*;
();

  localparam int unsigned CLK_PERIOD = 4;
  localparam int unsigned RST_CYCLES = 10;
  localparam int unsigned SEED       = 50910;
  localparam int unsigned LAT_MIN    = 1;
  localparam int unsigned LAT_MAX    = 4;
  // 2 SET, 6 GET, 1 foreign, ENEC plus DISEC, 1 reserved/RSTDAA
  localparam int unsigned NUM_FRAMES     = 12;
  localparam int unsigned TIMEOUT_CYCLES = 40 * NUM_FRAMES + RST_CYCLES;
  localparam logic [6:0]  DYN_ADDR       = 7'h2A;
  localparam logic [6:0]  STA_ADDR       = 7'h51;
  localparam logic [6:0]  FOREIGN_ADDR   = 7'h33;
  localparam ccc_opcode_e GET_CODES [6]  = '{CccDirectGetbcr, CccDirectGetdcr,
    CccDirectGetmwl, CccDirectGetmrl, CccDirectGetstatus, CccDirectGetpid};

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic [7:0]  ccc_i;
  logic        ccc_valid_i, rstart_det_i, stop_det_i;
  logic [7:0]  rx_data_i;
  logic        rx_done_i, tx_done_i;
  logic [6:0]  sta_addr_i, dyn_addr_i;
  logic        sta_addr_valid_i, dyn_addr_valid_i;
  logic [7:0]  get_bcr_i, get_dcr_i;
  logic [15:0] get_mwl_i, get_mrl_i, get_status_i;
  logic [47:0] get_pid_i;
  logic        done_fsm_o, next_ccc_o;
  logic        rx_req_bit_o, rx_req_byte_o, tx_req_bit_o, tx_req_byte_o;
  logic [7:0]  tx_value_o;
  logic        tx_pp_o, set_mwl_o, set_mrl_o, rstdaa_o;
  logic [15:0] mwl_o, mrl_o;
  logic        enec_ibi_o, enec_crr_o, enec_hj_o;
  logic        disec_ibi_o, disec_crr_o, disec_hj_o;

  int unsigned errors, checks, cycles;
  int unsigned n_set_mwl, n_set_mrl, n_rstdaa, n_next, n_done, n_stop;
  // Expected data bytes and expected bits as {push-pull, value}
  logic [7:0]  exp_bytes [$];
  logic [1:0]  exp_bits [$];
  logic [7:0]  exp_b;
  logic [1:0]  exp_bit;

  ccc_top ccc_top_i (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  `include "ccc_bus_model.svh"

  // Expected GET response with the first byte in the top lane
  function automatic int ref_get_bytes(input logic [7:0] code, input logic [7:0] bcr,
                                       input logic [7:0] dcr, input logic [15:0] mwl,
                                       input logic [15:0] mrl, input logic [15:0] status,
                                       input logic [47:0] pid, output logic [47:0] seq);
    seq = '0;
    case (code)
      CccDirectGetbcr: begin
        seq = {bcr, 40'h0};
        return 1;
      end
      CccDirectGetdcr: begin
        seq = {dcr, 40'h0};
        return 1;
      end
      CccDirectGetmwl: begin
        seq = {mwl, 32'h0};
        return 2;
      end
      CccDirectGetstatus: begin
        seq = {status, 32'h0};
        return 2;
      end
      CccDirectGetmrl: begin
        seq = {mrl, 8'hFF, 24'h0};
        return 3;
      end
      CccDirectGetpid: begin
        seq = pid;
        return 6;
      end
      default: return 0;
    endcase
  endfunction

  // Compare every ACK, GET byte and T-bit as the PHY accepts it
  always @(negedge clk_i) begin
    if (tx_done_i && tx_req_byte_o) begin
      if (exp_bytes.size() == 0) begin
        $display("DUT sent a data byte %h that was not expected", tx_value_o);
        errors++;
      end else begin
        exp_b = exp_bytes.pop_front();
        checks++;
        if ({tx_pp_o, tx_value_o} !== {1'b1, exp_b}) begin
          $display("MISMATCH tx_pp_o,tx_value_o: got %h expected %h",
                   {tx_pp_o, tx_value_o}, {1'b1, exp_b});
          errors++;
        end
      end
    end
    if (tx_done_i && tx_req_bit_o) begin
      if (exp_bits.size() == 0) begin
        $display("DUT sent a bit %h that was not expected", tx_value_o[0]);
        errors++;
      end else begin
        exp_bit = exp_bits.pop_front();
        checks++;
        if ({tx_pp_o, tx_value_o[0]} !== exp_bit) begin
          $display("MISMATCH tx_pp_o,tx_value_o[0]: got %h expected %h",
                   {tx_pp_o, tx_value_o[0]}, exp_bit);
          errors++;
        end
      end
    end
  end

  // Pulse counters
  always @(negedge clk_i) begin
    if (set_mwl_o) n_set_mwl++;
    if (set_mrl_o) n_set_mrl++;
    if (rstdaa_o) n_rstdaa++;
    if (next_ccc_o) n_next++;
    if (done_fsm_o) n_done++;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Run did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    logic [7:0]  b0, b1;
    logic [47:0] seq;
    logic [37:0] set_snap;
    int          len, k;
    int unsigned prev_cnt;
    void'($urandom(SEED));
    rst_ni <= 1'b0;
    ccc_i <= 8'h00;
    ccc_valid_i <= 1'b0;
    rstart_det_i <= 1'b0;
    stop_det_i <= 1'b0;
    rx_data_i <= 8'h00;
    rx_done_i <= 1'b0;
    tx_done_i <= 1'b0;
    sta_addr_i <= STA_ADDR;
    sta_addr_valid_i <= 1'b1;
    dyn_addr_i <= DYN_ADDR;
    dyn_addr_valid_i <= 1'b1;
    get_bcr_i <= 8'($urandom());
    get_dcr_i <= 8'($urandom());
    get_mwl_i <= 16'($urandom());
    get_mrl_i <= 16'($urandom());
    get_status_i <= 16'($urandom());
    get_pid_i <= {16'($urandom()), 32'($urandom())};
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (2) @(posedge clk_i);

    // Broadcast SETMWL and SETMRL
    b0 = 8'($urandom());
    b1 = 8'($urandom());
    send_bcast(CccBcastSetmwl, {b0, b1}, 2);
    if (mwl_o !== {b0, b1}) begin
      $display("MISMATCH mwl_o: got %h expected %h", mwl_o, {b0, b1});
      errors++;
    end
    b0 = 8'($urandom());
    b1 = 8'($urandom());
    send_bcast(CccBcastSetmrl, {b0, b1}, 2);
    if (mrl_o !== {b0, b1}) begin
      $display("MISMATCH mrl_o: got %h expected %h", mrl_o, {b0, b1});
      errors++;
    end
    if (n_set_mwl != 1 || n_set_mrl != 1) begin
      $display("MISMATCH set_mwl_o,set_mrl_o pulses: got %h,%h expected 1,1",
               n_set_mwl, n_set_mrl);
      errors++;
    end

    // Direct GETs to the dynamic address
    foreach (GET_CODES[i]) begin
      len = ref_get_bytes(GET_CODES[i], get_bcr_i, get_dcr_i, get_mwl_i, get_mrl_i,
                          get_status_i, get_pid_i, seq);
      exp_bits.push_back(2'b00);
      for (k = 0; k < len; k++) begin
        exp_bytes.push_back(seq[47 - 8 * k -: 8]);
        exp_bits.push_back({1'b1, k != len - 1});
      end
      open_direct(GET_CODES[i], DYN_ADDR, 1'b1);
      for (k = 0; k < 2 * len; k++) answer_tx();
      send_stop();
    end

    // Foreign address gets a NACK and changes nothing
    set_snap = {mwl_o, mrl_o, enec_ibi_o, enec_crr_o, enec_hj_o,
                disec_ibi_o, disec_crr_o, disec_hj_o};
    prev_cnt = n_set_mwl;
    exp_bits.push_back(2'b01);
    open_direct(CccDirectSetmwl, FOREIGN_ADDR, 1'b0);
    repeat (8) begin
      @(negedge clk_i);
      if (rx_req_byte_o || tx_req_byte_o) begin
        $display("Byte request raised after a NACKed address");
        errors++;
      end
    end
    send_stop();
    if ({mwl_o, mrl_o, enec_ibi_o, enec_crr_o, enec_hj_o, disec_ibi_o, disec_crr_o,
         disec_hj_o} !== set_snap || n_set_mwl != prev_cnt) begin
      $display("MISMATCH SET outputs after foreign address: expected %h unchanged", set_snap);
      errors++;
    end

    // Broadcast ENEC, then direct DISEC to the static address
    b0 = 8'($urandom());
    b1 = 8'($urandom());
    send_bcast(CccBcastEnec, {b0, 8'h00}, 1);
    if ({enec_hj_o, enec_crr_o, enec_ibi_o} !== {b0[3], b0[1], b0[0]}) begin
      $display("MISMATCH enec_hj_o,enec_crr_o,enec_ibi_o: got %h expected %h",
               {enec_hj_o, enec_crr_o, enec_ibi_o}, {b0[3], b0[1], b0[0]});
      errors++;
    end
    @(posedge clk_i);
    dyn_addr_valid_i <= 1'b0;
    exp_bits.push_back(2'b00);
    open_direct(CccDirectDisec, STA_ADDR, 1'b0);
    answer_rx(1'b1, b1);
    answer_rx(1'b0, 8'h80);
    send_stop();
    if ({disec_hj_o, disec_crr_o, disec_ibi_o} !== {b1[3], b1[1], b1[0]}) begin
      $display("MISMATCH disec_hj_o,disec_crr_o,disec_ibi_o: got %h expected %h",
               {disec_hj_o, disec_crr_o, disec_ibi_o}, {b1[3], b1[1], b1[0]});
      errors++;
    end

    // Reserved address hands over to a new RSTDAA CCC
    prev_cnt = n_next;
    exp_bits.push_back(2'b00);
    open_direct(CccDirectSetmrl, RSVD_ADDR, 1'b0);
    @(negedge clk_i);
    while (!next_ccc_o) @(negedge clk_i);
    send_ccc(CccBcastRstdaa);
    answer_rx(1'b0, 8'h80);
    send_stop();
    if (n_next != prev_cnt + 1 || n_rstdaa != 1) begin
      $display("MISMATCH next_ccc_o,rstdaa_o pulses: got %h,%h expected 1,1",
               n_next - prev_cnt, n_rstdaa);
      errors++;
    end

    if (exp_bytes.size() != 0 || exp_bits.size() != 0) begin
      $display("Some expected transfers were never sent by the DUT");
      errors++;
    end
    if (n_done != n_stop) begin
      $display("MISMATCH done_fsm_o pulses: got %h expected %h", n_done, n_stop);
      errors++;
    end
    $display("Checks: %0d, errors: %0d, frames: %0d, cycles: %0d",
             checks, errors, n_stop, cycles);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- hdl/ccc_addr_match.sv
// Direct CCC address match
`timescale 1ns/10ps

module ccc_addr_match
  import i3c_ccc_pkg::*;
  import ccc_ctrl_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  ccc_state_e state_i,
  input  logic [7:0] rx_data_i,
  input  logic       rx_done_i,
  input  logic [6:0] sta_addr_i,
  input  logic       sta_addr_valid_i,
  input  logic [6:0] dyn_addr_i,
  input  logic       dyn_addr_valid_i,
  output logic       addr_ours_o,
  output logic       addr_rsvd_o,
  output logic       rnw_o
);

  logic [6:0] addr_q;
  logic       rnw_q;
  logic       addr_vld_q;
  logic       hit;

  // Latched address is only meaningful until the next CCC starts
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q     <= '0;
      rnw_q      <= 1'b0;
      addr_vld_q <= 1'b0;
    end else if (state_i == RxAddr && rx_done_i) begin
      addr_q     <= rx_data_i[7:1];
      rnw_q      <= rx_data_i[0];
      addr_vld_q <= 1'b1;
    end else if (state_i == WaitCcc) begin
      addr_vld_q <= 1'b0;
    end
  end

  // Dynamic address takes priority over the static one
  always_comb begin
    if (dyn_addr_valid_i) hit = (addr_q == dyn_addr_i);
    else if (sta_addr_valid_i) hit = (addr_q == sta_addr_i);
    else hit = 1'b0;
  end

  assign addr_ours_o = addr_vld_q && hit;
  assign addr_rsvd_o = addr_vld_q && (addr_q == RSVD_ADDR);
  assign rnw_o       = rnw_q;

endmodule

//--- hdl/ccc_ctrl_pkg.sv
// CCC handler internal definitions
package ccc_ctrl_pkg;

  typedef enum logic [4:0] {
    Idle,
    WaitCcc,
    RxTbit,
    RxByte,
    RxAddr,
    TxAddrAck,
    RxData,
    RxDataTbit,
    TxData,
    TxDataTbit,
    WaitBusCond,
    NextCcc,
    DoneCcc
  } ccc_state_e;

  // Kind of request currently presented to the bus PHY
  typedef enum logic [2:0] {
    ReqNone,
    ReqRxBit,
    ReqRxByte,
    ReqTxBit,
    ReqTxByte
  } phy_req_e;

endpackage

//--- hdl/ccc_fsm.sv
// CCC frame state machine
`timescale 1ns/10ps

module ccc_fsm
  import i3c_ccc_pkg::*;
  import ccc_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [7:0]  ccc_i,
  input  logic        ccc_valid_i,
  input  logic        rstart_det_i,
  input  logic        stop_det_i,
  input  logic        rx_done_i,
  input  logic        tx_done_i,
  input  logic        addr_ours_i,
  input  logic        addr_rsvd_i,
  input  logic        rnw_i,
  input  logic [7:0]  tx_byte_i,
  input  logic        last_byte_i,
  output ccc_state_e  state_o,
  output ccc_opcode_e cmd_o,
  output logic        rx_req_bit_o,
  output logic        rx_req_byte_o,
  output logic        tx_req_bit_o,
  output logic        tx_req_byte_o,
  output logic [7:0]  tx_value_o,
  output logic        tx_pp_o,
  output logic        done_fsm_o,
  output logic        next_ccc_o
);

  ccc_state_e  state_q, state_d;
  ccc_opcode_e cmd_q;
  phy_req_e    req;
  logic        is_direct;

  assign is_direct = cmd_q[7];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_q <= ccc_opcode_e'(8'h00);
    end else if (ccc_valid_i) begin
      cmd_q <= ccc_opcode_e'(ccc_i);
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle:        state_d = WaitCcc;
      WaitCcc:     if (ccc_valid_i) state_d = RxTbit;
      RxTbit: begin
        if (rx_done_i) state_d = is_direct ? RxByte : RxData;
      end
      // Either Sr with an address, or an unexpected data byte
      RxByte: begin
        if (rstart_det_i) state_d = RxAddr;
        else if (rx_done_i) state_d = WaitBusCond;
      end
      RxAddr:      if (rx_done_i) state_d = TxAddrAck;
      TxAddrAck: begin
        if (tx_done_i) begin
          if (addr_rsvd_i) state_d = NextCcc;
          else if (addr_ours_i && rnw_i) state_d = TxData;
          else if (addr_ours_i) state_d = RxData;
          else state_d = WaitBusCond;
        end
      end
      RxData: begin
        if (rstart_det_i) state_d = RxAddr;
        else if (rx_done_i) state_d = RxDataTbit;
      end
      RxDataTbit:  if (rx_done_i) state_d = RxData;
      TxData: begin
        if (rstart_det_i) state_d = RxAddr;
        else if (tx_done_i) state_d = TxDataTbit;
      end
      TxDataTbit: begin
        if (tx_done_i) state_d = last_byte_i ? WaitBusCond : TxData;
      end
      WaitBusCond: if (rstart_det_i) state_d = RxAddr;
      NextCcc:     state_d = WaitCcc;
      DoneCcc:     state_d = Idle;
      default:     state_d = Idle;
    endcase
  end

  // Stop ends the frame from anywhere
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else if (stop_det_i) begin
      state_q <= DoneCcc;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    req        = ReqNone;
    tx_value_o = 8'h00;
    tx_pp_o    = 1'b0;
    case (state_q)
      RxTbit, RxDataTbit: req = ReqRxBit;
      RxAddr:             req = ReqRxByte;
      RxByte, RxData: begin
        // Withdraw the byte request once Sr shows up
        if (!rstart_det_i) req = ReqRxByte;
      end
      TxAddrAck: begin
        req        = ReqTxBit;
        tx_value_o = {7'h00, ~(addr_ours_i | addr_rsvd_i)};
      end
      TxData: begin
        req        = ReqTxByte;
        tx_value_o = tx_byte_i;
        tx_pp_o    = 1'b1;
      end
      TxDataTbit: begin
        req        = ReqTxBit;
        tx_value_o = {7'h00, ~last_byte_i};
        tx_pp_o    = 1'b1;
      end
      default: req = ReqNone;
    endcase
  end

  assign rx_req_bit_o  = (req == ReqRxBit);
  assign rx_req_byte_o = (req == ReqRxByte);
  assign tx_req_bit_o  = (req == ReqTxBit);
  assign tx_req_byte_o = (req == ReqTxByte);

  assign done_fsm_o = (state_q == DoneCcc);
  assign next_ccc_o = (state_q == NextCcc);
  assign state_o    = state_q;
  assign cmd_o      = cmd_q;

endmodule

//--- hdl/ccc_get_handler.sv
// GET CCC response generator
`timescale 1ns/10ps

module ccc_get_handler
  import i3c_ccc_pkg::*;
  import ccc_ctrl_pkg::*;
#(
  parameter int unsigned CNT_W = 8
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  ccc_state_e  state_i,
  input  ccc_opcode_e cmd_i,
  input  logic        tx_done_i,
  input  logic [7:0]  get_bcr_i,
  input  logic [7:0]  get_dcr_i,
  input  logic [15:0] get_mwl_i,
  input  logic [15:0] get_mrl_i,
  input  logic [15:0] get_status_i,
  input  logic [47:0] get_pid_i,
  output logic [7:0]  tx_byte_o,
  output logic        last_byte_o
);

  logic [CNT_W-1:0] idx_q;
  logic [CNT_W-1:0] get_len;
  logic [47:0]      resp;

  // Response right-aligned, first byte sent sits at the highest used lane
  always_comb begin
    get_len = '0;
    resp    = '0;
    case (cmd_i)
      CccDirectGetbcr: begin
        get_len = CNT_W'(1);
        resp    = {40'h0, get_bcr_i};
      end
      CccDirectGetdcr: begin
        get_len = CNT_W'(1);
        resp    = {40'h0, get_dcr_i};
      end
      CccDirectGetmwl: begin
        get_len = CNT_W'(2);
        resp    = {32'h0, get_mwl_i};
      end
      CccDirectGetstatus: begin
        get_len = CNT_W'(2);
        resp    = {32'h0, get_status_i};
      end
      // Third byte is the max IBI payload, fixed at FF
      CccDirectGetmrl: begin
        get_len = CNT_W'(3);
        resp    = {24'h0, get_mrl_i, 8'hFF};
      end
      CccDirectGetpid: begin
        get_len = CNT_W'(6);
        resp    = get_pid_i;
      end
      default: begin
      end
    endcase
  end

  // Remaining byte count, zero once the last byte is out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= '0;
    end else if (state_i == TxAddrAck) begin
      idx_q <= get_len;
    end else if (state_i == TxData && tx_done_i && idx_q != '0) begin
      idx_q <= idx_q - 1'b1;
    end
  end

  always_comb begin
    case (idx_q)
      CNT_W'(6): tx_byte_o = resp[47:40];
      CNT_W'(5): tx_byte_o = resp[39:32];
      CNT_W'(4): tx_byte_o = resp[31:24];
      CNT_W'(3): tx_byte_o = resp[23:16];
      CNT_W'(2): tx_byte_o = resp[15:8];
      CNT_W'(1): tx_byte_o = resp[7:0];
      default:   tx_byte_o = 8'h00;
    endcase
  end

  assign last_byte_o = (idx_q == '0);

endmodule

//--- hdl/ccc_set_handler.sv
// SET CCC data handler
`timescale 1ns/10ps

module ccc_set_handler
  import i3c_ccc_pkg::*;
  import ccc_ctrl_pkg::*;
#(
  parameter int unsigned CNT_W = 8
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  ccc_state_e  state_i,
  input  ccc_opcode_e cmd_i,
  input  logic [7:0]  rx_data_i,
  input  logic        rx_done_i,
  input  logic        addr_rsvd_i,
  output logic        set_mwl_o,
  output logic [15:0] mwl_o,
  output logic        set_mrl_o,
  output logic [15:0] mrl_o,
  output logic        enec_ibi_o,
  output logic        enec_crr_o,
  output logic        enec_hj_o,
  output logic        disec_ibi_o,
  output logic        disec_crr_o,
  output logic        disec_hj_o,
  output logic        rstdaa_o
);

  logic [7:0]       rx_byte_q;
  logic [CNT_W-1:0] data_cnt_q;
  logic             apply;
  logic             first, second;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_byte_q <= '0;
    end else if (state_i == RxData && rx_done_i) begin
      rx_byte_q <= rx_data_i;
    end
  end

  // Data byte count within the current CCC or address
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_cnt_q <= '0;
    end else if (state_i == WaitCcc || state_i == RxAddr) begin
      data_cnt_q <= '0;
    end else if (state_i == RxDataTbit && rx_done_i && data_cnt_q != '1) begin
      data_cnt_q <= data_cnt_q + 1'b1;
    end
  end

  // A byte takes effect once its T-bit is in
  assign apply  = (state_i == RxDataTbit) && rx_done_i && !addr_rsvd_i;
  assign first  = apply && (data_cnt_q == CNT_W'(0));
  assign second = apply && (data_cnt_q == CNT_W'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      set_mwl_o   <= 1'b0;
      set_mrl_o   <= 1'b0;
      mwl_o       <= '0;
      mrl_o       <= '0;
      enec_ibi_o  <= 1'b0;
      enec_crr_o  <= 1'b0;
      enec_hj_o   <= 1'b0;
      disec_ibi_o <= 1'b0;
      disec_crr_o <= 1'b0;
      disec_hj_o  <= 1'b0;
      rstdaa_o    <= 1'b0;
    end else begin
      set_mwl_o <= 1'b0;
      set_mrl_o <= 1'b0;
      rstdaa_o  <= (cmd_i == CccBcastRstdaa) && (state_i == RxTbit) && rx_done_i;
      case (cmd_i)
        CccBcastSetmwl, CccDirectSetmwl: begin
          if (first) mwl_o[15:8] <= rx_byte_q;
          if (second) begin
            mwl_o[7:0] <= rx_byte_q;
            set_mwl_o  <= 1'b1;
          end
        end
        CccBcastSetmrl, CccDirectSetmrl: begin
          if (first) mrl_o[15:8] <= rx_byte_q;
          if (second) begin
            mrl_o[7:0] <= rx_byte_q;
            set_mrl_o  <= 1'b1;
          end
        end
        CccBcastEnec, CccDirectEnec: begin
          if (first) begin
            enec_ibi_o <= rx_byte_q[EVT_IBI_BIT];
            enec_crr_o <= rx_byte_q[EVT_CRR_BIT];
            enec_hj_o  <= rx_byte_q[EVT_HJ_BIT];
          end
        end
        CccBcastDisec, CccDirectDisec: begin
          if (first) begin
            disec_ibi_o <= rx_byte_q[EVT_IBI_BIT];
            disec_crr_o <= rx_byte_q[EVT_CRR_BIT];
            disec_hj_o  <= rx_byte_q[EVT_HJ_BIT];
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

//--- hdl/ccc_top.sv
// I3C target CCC handler top
`timescale 1ns/10ps

module ccc_top
  import i3c_ccc_pkg::*;
  import ccc_ctrl_pkg::*;
#(
  parameter int unsigned CNT_W = 8
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [7:0]  ccc_i,
  input  logic        ccc_valid_i,
  input  logic        rstart_det_i,
  input  logic        stop_det_i,
  input  logic [7:0]  rx_data_i,
  input  logic        rx_done_i,
  input  logic        tx_done_i,
  input  logic [6:0]  sta_addr_i,
  input  logic        sta_addr_valid_i,
  input  logic [6:0]  dyn_addr_i,
  input  logic        dyn_addr_valid_i,
  input  logic [7:0]  get_bcr_i,
  input  logic [7:0]  get_dcr_i,
  input  logic [15:0] get_mwl_i,
  input  logic [15:0] get_mrl_i,
  input  logic [15:0] get_status_i,
  input  logic [47:0] get_pid_i,
  output logic        done_fsm_o,
  output logic        next_ccc_o,
  output logic        rx_req_bit_o,
  output logic        rx_req_byte_o,
  output logic        tx_req_bit_o,
  output logic        tx_req_byte_o,
  output logic [7:0]  tx_value_o,
  output logic        tx_pp_o,
  output logic        set_mwl_o,
  output logic [15:0] mwl_o,
  output logic        set_mrl_o,
  output logic [15:0] mrl_o,
  output logic        enec_ibi_o,
  output logic        enec_crr_o,
  output logic        enec_hj_o,
  output logic        disec_ibi_o,
  output logic        disec_crr_o,
  output logic        disec_hj_o,
  output logic        rstdaa_o
);

  ccc_state_e  state;
  ccc_opcode_e cmd;
  logic        addr_ours, addr_rsvd, rnw;
  logic [7:0]  tx_byte;
  logic        last_byte;

  ccc_fsm fsm_i (
    .clk_i, .rst_ni, .ccc_i, .ccc_valid_i, .rstart_det_i, .stop_det_i,
    .rx_done_i, .tx_done_i,
    .addr_ours_i (addr_ours),
    .addr_rsvd_i (addr_rsvd),
    .rnw_i       (rnw),
    .tx_byte_i   (tx_byte),
    .last_byte_i (last_byte),
    .state_o     (state),
    .cmd_o       (cmd),
    .rx_req_bit_o, .rx_req_byte_o, .tx_req_bit_o, .tx_req_byte_o,
    .tx_value_o, .tx_pp_o, .done_fsm_o, .next_ccc_o
  );

  ccc_addr_match addr_match_i (
    .clk_i, .rst_ni,
    .state_i     (state),
    .rx_data_i, .rx_done_i,
    .sta_addr_i, .sta_addr_valid_i, .dyn_addr_i, .dyn_addr_valid_i,
    .addr_ours_o (addr_ours),
    .addr_rsvd_o (addr_rsvd),
    .rnw_o       (rnw)
  );

  ccc_set_handler #(.CNT_W(CNT_W)) set_handler_i (
    .clk_i, .rst_ni,
    .state_i     (state),
    .cmd_i       (cmd),
    .rx_data_i, .rx_done_i,
    .addr_rsvd_i (addr_rsvd),
    .set_mwl_o, .mwl_o, .set_mrl_o, .mrl_o,
    .enec_ibi_o, .enec_crr_o, .enec_hj_o,
    .disec_ibi_o, .disec_crr_o, .disec_hj_o,
    .rstdaa_o
  );

  ccc_get_handler #(.CNT_W(CNT_W)) get_handler_i (
    .clk_i, .rst_ni,
    .state_i     (state),
    .cmd_i       (cmd),
    .tx_done_i,
    .get_bcr_i, .get_dcr_i, .get_mwl_i, .get_mrl_i, .get_status_i, .get_pid_i,
    .tx_byte_o   (tx_byte),
    .last_byte_o (last_byte)
  );

endmodule

//--- hdl/i3c_ccc_pkg.sv
// I3C CCC protocol definitions
package i3c_ccc_pkg;

  // Broadcast address used for CCCs and reserved-address framing
  localparam logic [6:0] RSVD_ADDR = 7'h7E;

  // Supported command codes, bit 7 set means direct
  typedef enum logic [7:0] {
    CccBcastEnec      = 8'h00,
    CccBcastDisec     = 8'h01,
    CccBcastRstdaa    = 8'h06,
    CccBcastSetmwl    = 8'h09,
    CccBcastSetmrl    = 8'h0A,
    CccDirectEnec     = 8'h80,
    CccDirectDisec    = 8'h81,
    CccDirectSetmwl   = 8'h89,
    CccDirectSetmrl   = 8'h8A,
    CccDirectGetmwl   = 8'h8B,
    CccDirectGetmrl   = 8'h8C,
    CccDirectGetpid   = 8'h8D,
    CccDirectGetbcr   = 8'h8E,
    CccDirectGetdcr   = 8'h8F,
    CccDirectGetstatus = 8'h90
  } ccc_opcode_e;

  // ENEC and DISEC event bit positions
  localparam int unsigned EVT_IBI_BIT = 0;
  localparam int unsigned EVT_CRR_BIT = 1;
  localparam int unsigned EVT_HJ_BIT  = 3;

endpackage
